// File: include/ex_mem_cfg.svh
`ifndef EX_MEM_CFG_SVH
`define EX_MEM_CFG_SVH

// datapath and address width of the integer pipeline.
`define XLEN_W 32

// register number width, for 32 architectural registers.
`define REG_W 5

// data memory depth in 32-bit words, must be a power of two.
`define DMEM_WORDS 256

// register written by jal.
`define LINK_REG 31

`endif

// File: src/ex_mem_pkg.sv
`include "ex_mem_cfg.svh"

package ex_mem_pkg;

   // pipeline control level from the hazard unit. the spare code acts as a stall.
   typedef enum logic [1:0] {
      ctrl_go     = 2'b00,
      ctrl_squash = 2'b01,
      ctrl_stall  = 2'b10,
      ctrl_rsvd   = 2'b11
   } pipe_ctrl_e;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_nor  = 4'd5,
      alu_slt  = 4'd6,
      alu_sltu = 4'd7,
      alu_sll  = 4'd8,
      alu_srl  = 4'd9,
      alu_sra  = 4'd10,
      alu_lui  = 4'd11
   } alu_op_e;

   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } mem_size_e;

   // decoded instruction as it leaves the decode/execute boundary.
   typedef struct packed {
      logic [`XLEN_W-1:0] pc4;
      logic [`XLEN_W-1:0] bus_a;
      logic [`XLEN_W-1:0] bus_b;
      logic [`XLEN_W-1:0] imm32;
      logic [4:0]         shamt;
      alu_op_e            alu_op;
      logic               alu_src;
      logic               mem_rd;
      logic               mem_wr;
      logic               reg_wr;
      logic               branch;
      logic               jr;
      logic               jump;
      logic               link;
      logic               op0;
      mem_size_e          dsize;
      logic [`REG_W-1:0]  rd;
   } id_ex_t;

   // fresh marks an entry loaded on a go edge, so nothing acts on it twice.
   typedef struct packed {
      logic [`XLEN_W-1:0] alu_res;
      logic [`XLEN_W-1:0] store_data;
      logic [`XLEN_W-1:0] link_val;
      logic               mem_rd;
      logic               mem_wr;
      logic               reg_wr;
      logic               link;
      logic               op0;
      mem_size_e          dsize;
      logic [`REG_W-1:0]  rd;
      logic               fresh;
   } ex_mem_t;

   typedef struct packed {
      logic               taken;
      logic [`XLEN_W-1:0] target;
   } redirect_t;

   typedef struct packed {
      logic               valid;
      logic [`REG_W-1:0]  rd;
      logic [`XLEN_W-1:0] data;
   } wb_t;

endpackage

// File: src/alu_unit.sv
`timescale 1ns/1ns
`include "ex_mem_cfg.svh"

module alu_unit (
   input  ex_mem_pkg::id_ex_t       id_ex,
   output logic [`XLEN_W-1:0]       alu_res
);

   import ex_mem_pkg::*;

   logic [`XLEN_W-1:0] op_a;
   logic [`XLEN_W-1:0] op_b;
   logic [`XLEN_W-1:0] sum;
   logic [`XLEN_W-1:0] diff;
   logic               lt_signed;
   logic               lt_unsigned;

   // the immediate replaces bus_b for i-type instructions.
   assign op_a = id_ex.bus_a;
   assign op_b = id_ex.alu_src ? id_ex.imm32 : id_ex.bus_b;

   assign sum  = op_a + op_b;
   assign diff = op_a - op_b;

   assign lt_signed   = $signed(op_a) < $signed(op_b);
   assign lt_unsigned = op_a < op_b;

   always_comb begin
      case (id_ex.alu_op)
         alu_add: begin
            alu_res = sum;
         end
         alu_sub: begin
            alu_res = diff;
         end
         alu_and: begin
            alu_res = op_a & op_b;
         end
         alu_or: begin
            alu_res = op_a | op_b;
         end
         alu_xor: begin
            alu_res = op_a ^ op_b;
         end
         alu_nor: begin
            alu_res = ~(op_a | op_b);
         end
         alu_slt: begin
            alu_res = {{(`XLEN_W-1){1'b0}}, lt_signed};
         end
         alu_sltu: begin
            alu_res = {{(`XLEN_W-1){1'b0}}, lt_unsigned};
         end
         // shifts take the register operand and the shamt field.
         alu_sll: begin
            alu_res = id_ex.bus_b << id_ex.shamt;
         end
         alu_srl: begin
            alu_res = id_ex.bus_b >> id_ex.shamt;
         end
         alu_sra: begin
            alu_res = $signed(id_ex.bus_b) >>> id_ex.shamt;
         end
         alu_lui: begin
            alu_res = id_ex.imm32 << 16;
         end
         default: begin
            alu_res = '0;
         end
      endcase
   end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ns
`include "ex_mem_cfg.svh"

module branch_unit (
   input  ex_mem_pkg::id_ex_t       id_ex,
   output ex_mem_pkg::redirect_t    redirect,
   output logic [`XLEN_W-1:0]       link_val
);

   logic               operands_eq;
   logic               branch_cond;
   logic [`XLEN_W-1:0] branch_target;
   logic [`XLEN_W-1:0] jump_target;

   assign operands_eq = (id_ex.bus_a == id_ex.bus_b);

   // op0 flips the sense, so op0 set gives bne and clear gives beq.
   assign branch_cond = id_ex.branch && (operands_eq != id_ex.op0);

   // the immediate counts words relative to the incremented pc.
   assign branch_target = id_ex.pc4 + {id_ex.imm32[`XLEN_W-3:0], 2'b00};

   // jumps stay inside the current 256 MB region.
   assign jump_target = {id_ex.pc4[`XLEN_W-1:`XLEN_W-4], id_ex.imm32[25:0], 2'b00};

   always_comb begin
      redirect.taken  = 1'b0;
      redirect.target = branch_target;
      if (id_ex.jr) begin
         redirect.taken  = 1'b1;
         redirect.target = id_ex.bus_a;
      end else if (id_ex.jump) begin
         redirect.taken  = 1'b1;
         redirect.target = jump_target;
      end else if (branch_cond) begin
         redirect.taken  = 1'b1;
      end
   end

   // return address for jal and jalr.
   assign link_val = id_ex.pc4;

endmodule

// File: src/ex_mem_reg.sv
`timescale 1ns/1ns
`include "ex_mem_cfg.svh"

module ex_mem_reg (
   input  logic                     clk,
   input  logic                     rst,
   input  ex_mem_pkg::pipe_ctrl_e   ctrl,
   input  ex_mem_pkg::id_ex_t       id_ex,
   input  logic [`XLEN_W-1:0]       alu_res,
   input  logic [`XLEN_W-1:0]       link_val,
   input  ex_mem_pkg::redirect_t    redirect_d,
   output ex_mem_pkg::ex_mem_t      ex_mem,
   output ex_mem_pkg::redirect_t    redirect
);

   import ex_mem_pkg::*;

   ex_mem_t ex_mem_d;

   // store data is always the second register operand.
   always_comb begin
      ex_mem_d.alu_res    = alu_res;
      ex_mem_d.store_data = id_ex.bus_b;
      ex_mem_d.link_val   = link_val;
      ex_mem_d.mem_rd     = id_ex.mem_rd;
      ex_mem_d.mem_wr     = id_ex.mem_wr;
      ex_mem_d.reg_wr     = id_ex.reg_wr;
      ex_mem_d.link       = id_ex.link;
      ex_mem_d.op0        = id_ex.op0;
      ex_mem_d.dsize      = id_ex.dsize;
      ex_mem_d.rd         = id_ex.rd;
      ex_mem_d.fresh      = 1'b1;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         ex_mem.mem_wr  <= 1'b0;
         ex_mem.reg_wr  <= 1'b0;
         ex_mem.fresh   <= 1'b0;
         redirect.taken <= 1'b0;
      end else begin
         case (ctrl)
            ctrl_go: begin
               ex_mem   <= ex_mem_d;
               redirect <= redirect_d;
            end
            ctrl_squash: begin
               ex_mem.mem_wr  <= 1'b0;
               ex_mem.reg_wr  <= 1'b0;
               ex_mem.fresh   <= 1'b0;
               redirect.taken <= 1'b0;
            end
            // a held entry keeps its fields but must not act a second time.
            default: begin
               ex_mem.fresh   <= 1'b0;
               redirect.taken <= 1'b0;
            end
         endcase
      end
   end

endmodule

// File: src/mem_access.sv
`timescale 1ns/1ns
`include "ex_mem_cfg.svh"

module mem_access (
   input  logic                     clk,
   input  logic                     rst,
   input  ex_mem_pkg::ex_mem_t      ex_mem,
   output ex_mem_pkg::wb_t          wb
);

   import ex_mem_pkg::*;

   localparam int ADDR_W = $clog2(`DMEM_WORDS);

   logic [`XLEN_W-1:0] dmem [`DMEM_WORDS];

   logic [ADDR_W-1:0]  word_idx;
   logic [1:0]         lane;
   logic [3:0]         byte_en;
   logic [`XLEN_W-1:0] wr_data;
   logic [`XLEN_W-1:0] rd_word;
   logic [7:0]         rd_byte;
   logic [15:0]        rd_half;
   logic [`XLEN_W-1:0] load_data;
   logic [`XLEN_W-1:0] wb_data;
   logic               store_en;

   assign word_idx = ex_mem.alu_res[ADDR_W+1:2];
   assign lane     = ex_mem.alu_res[1:0];
   assign store_en = ex_mem.fresh && ex_mem.mem_wr;

   // the narrow store value is replicated so every lane sees it.
   always_comb begin
      case (ex_mem.dsize)
         size_byte: begin
            byte_en = 4'b0001 << lane;
            wr_data = {4{ex_mem.store_data[7:0]}};
         end
         size_half: begin
            byte_en = lane[1] ? 4'b1100 : 4'b0011;
            wr_data = {2{ex_mem.store_data[15:0]}};
         end
         default: begin
            byte_en = 4'b1111;
            wr_data = ex_mem.store_data;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (store_en && byte_en[i]) begin
            dmem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
         end
      end
   end

   assign rd_word = dmem[word_idx];
   assign rd_byte = rd_word[{lane, 3'b000} +: 8];
   assign rd_half = lane[1] ? rd_word[31:16] : rd_word[15:0];

   // op0 on a load selects zero extension.
   always_comb begin
      case (ex_mem.dsize)
         size_byte: begin
            load_data = {{(`XLEN_W-8){rd_byte[7] & ~ex_mem.op0}}, rd_byte};
         end
         size_half: begin
            load_data = {{(`XLEN_W-16){rd_half[15] & ~ex_mem.op0}}, rd_half};
         end
         default: begin
            load_data = rd_word;
         end
      endcase
   end

   assign wb_data = ex_mem.mem_rd ? load_data :
                    ex_mem.link   ? ex_mem.link_val : ex_mem.alu_res;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wb.valid <= 1'b0;
      end else begin
         wb.valid <= ex_mem.fresh && ex_mem.reg_wr && (ex_mem.rd != '0);
         wb.rd    <= ex_mem.rd;
         wb.data  <= wb_data;
      end
   end

endmodule

// File: src/ex_mem_top.sv
`timescale 1ns/1ns
`include "ex_mem_cfg.svh"

module ex_mem_top (
   input  logic                     clk,
   input  logic                     rst,
   input  ex_mem_pkg::pipe_ctrl_e   ctrl,
   input  ex_mem_pkg::id_ex_t       id_ex,
   output ex_mem_pkg::redirect_t    redirect,
   output ex_mem_pkg::wb_t          wb
);

   import ex_mem_pkg::*;

   logic [`XLEN_W-1:0] alu_res;
   logic [`XLEN_W-1:0] link_val;
   redirect_t          redirect_d;
   ex_mem_t            ex_mem;

   // both execute units see the same decoded instruction.
   alu_unit u_alu (
      .id_ex   (id_ex),
      .alu_res (alu_res)
   );

   branch_unit u_branch (
      .id_ex    (id_ex),
      .redirect (redirect_d),
      .link_val (link_val)
   );

   ex_mem_reg u_ex_mem_reg (
      .clk        (clk),
      .rst        (rst),
      .ctrl       (ctrl),
      .id_ex      (id_ex),
      .alu_res    (alu_res),
      .link_val   (link_val),
      .redirect_d (redirect_d),
      .ex_mem     (ex_mem),
      .redirect   (redirect)
   );

   mem_access u_mem (
      .clk    (clk),
      .rst    (rst),
      .ex_mem (ex_mem),
      .wb     (wb)
   );

endmodule

// File: tests/ex_mem_tb.sv
`timescale 1ns/1ns
`include "ex_mem_cfg.svh"

module ex_mem_tb;

   import ex_mem_pkg::*;

   localparam int MEM_AW = $clog2(`DMEM_WORDS);
   localparam int DRAIN_LIMIT = 40;

   logic       clk = 1'b0;
   logic       rst;
   pipe_ctrl_e ctrl;
   id_ex_t     id_ex;
   redirect_t  redirect;
   wb_t        wb;

   logic [`XLEN_W-1:0] shadow [`DMEM_WORDS];
   int        cyc = 0;
   int        cur_test = 0;
   string     tname [5];
   int        chk_cnt [5];
   int        err_cnt [5];
   int        rd_due_q [$];
   redirect_t rd_exp_q [$];
   int        rd_tid_q [$];
   int        wb_due_q [$];
   wb_t       wb_exp_q [$];
   int        wb_tid_q [$];
   redirect_t exp_r;
   wb_t       exp_w;
   int        tid;

   ex_mem_top u_dut (
      .clk      (clk),
      .rst      (rst),
      .ctrl     (ctrl),
      .id_ex    (id_ex),
      .redirect (redirect),
      .wb       (wb)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // expected outcome of one captured instruction, with the shadow memory updated in order.
   function automatic void ref_exec(input id_ex_t ins, output redirect_t er, output wb_t ew);
      logic [31:0]       b;
      logic [31:0]       res;
      logic [31:0]       word;
      logic [31:0]       ld;
      logic [7:0]        lb;
      logic [15:0]       lh;
      logic [MEM_AW-1:0] idx;
      logic [1:0]        ln;
      b = ins.alu_src ? ins.imm32 : ins.bus_b;
      case (ins.alu_op)
         alu_add:  res = ins.bus_a + b;
         alu_sub:  res = ins.bus_a - b;
         alu_and:  res = ins.bus_a & b;
         alu_or:   res = ins.bus_a | b;
         alu_xor:  res = ins.bus_a ^ b;
         alu_nor:  res = ~(ins.bus_a | b);
         alu_slt:  res = ($signed(ins.bus_a) < $signed(b)) ? 32'd1 : 32'd0;
         alu_sltu: res = (ins.bus_a < b) ? 32'd1 : 32'd0;
         alu_sll:  res = ins.bus_b << ins.shamt;
         alu_srl:  res = ins.bus_b >> ins.shamt;
         alu_sra:  res = $unsigned($signed(ins.bus_b) >>> ins.shamt);
         alu_lui:  res = ins.imm32 << 16;
         default:  res = 32'd0;
      endcase
      idx = res[MEM_AW+1:2];
      ln = res[1:0];
      word = shadow[idx];
      if (ins.mem_wr) begin
         case (ins.dsize)
            size_byte: word[{ln, 3'b000} +: 8] = ins.bus_b[7:0];
            size_half: word[{ln[1], 4'b0000} +: 16] = ins.bus_b[15:0];
            default:   word = ins.bus_b;
         endcase
         shadow[idx] = word;
      end
      lb = word[{ln, 3'b000} +: 8];
      lh = word[{ln[1], 4'b0000} +: 16];
      case (ins.dsize)
         size_byte: ld = ins.op0 ? {24'd0, lb} : {{24{lb[7]}}, lb};
         size_half: ld = ins.op0 ? {16'd0, lh} : {{16{lh[15]}}, lh};
         default:   ld = word;
      endcase
      er.taken = ins.jr || ins.jump || (ins.branch && ((ins.bus_a == ins.bus_b) != ins.op0));
      if (ins.jr)
         er.target = ins.bus_a;
      else if (ins.jump)
         er.target = {ins.pc4[31:28], ins.imm32[25:0], 2'b00};
      else
         er.target = ins.pc4 + (ins.imm32 << 2);
      ew.valid = ins.reg_wr && (ins.rd != 5'd0);
      ew.rd = ins.rd;
      ew.data = ins.mem_rd ? ld : (ins.link ? ins.pc4 : res);
   endfunction

   function automatic id_ex_t gen_alu();
      id_ex_t      ins;
      logic [31:0] r;
      logic [31:0] op;
      ins = '0;
      ins.pc4 = $urandom;
      ins.bus_a = $urandom;
      ins.bus_b = $urandom;
      r = $urandom;
      ins.imm32 = r[31] ? {{16{r[15]}}, r[15:0]} : {16'd0, r[15:0]};
      ins.shamt = r[20:16];
      ins.alu_src = r[21];
      ins.rd = r[26:22];
      op = $urandom_range(0, 11);
      ins.alu_op = alu_op_e'(op[3:0]);
      ins.reg_wr = 1'b1;
      return ins;
   endfunction

   function automatic id_ex_t gen_ctl();
      id_ex_t      ins;
      logic [31:0] r;
      int          kind;
      ins = '0;
      r = $urandom;
      ins.pc4 = $urandom;
      ins.bus_a = $urandom;
      ins.bus_b = r[0] ? ins.bus_a : $urandom;
      ins.imm32 = $urandom;
      kind = $urandom_range(0, 4);
      case (kind)
         0: begin
            ins.branch = 1'b1;
            ins.op0 = r[1];
         end
         1: ins.jump = 1'b1;
         2: ins.jr = 1'b1;
         3: begin
            ins.jump = 1'b1;
            ins.link = 1'b1;
            ins.reg_wr = 1'b1;
            ins.rd = 5'(`LINK_REG);
         end
         default: begin
            ins.jr = 1'b1;
            ins.link = 1'b1;
            ins.reg_wr = 1'b1;
            ins.rd = r[8:4];
         end
      endcase
      return ins;
   endfunction

   function automatic id_ex_t mem_op(input logic st, input logic [1:0] sz, input logic [3:0] w,
                                     input logic [1:0] ln, input logic [31:0] data,
                                     input logic zx, input logic [4:0] rd);
      id_ex_t ins;
      ins = '0;
      ins.pc4 = $urandom;
      ins.bus_a = {26'd0, w, 2'b00};
      ins.bus_b = data;
      ins.imm32 = {30'd0, ln};
      ins.alu_op = alu_add;
      ins.alu_src = 1'b1;
      ins.dsize = mem_size_e'(sz);
      ins.op0 = zx;
      ins.mem_wr = st;
      ins.mem_rd = !st;
      ins.reg_wr = !st;
      ins.rd = rd;
      return ins;
   endfunction

   // accesses stay aligned and inside the sixteen words written first.
   function automatic id_ex_t gen_mem();
      logic [31:0] r;
      logic [1:0]  sz;
      logic [1:0]  ln;
      logic [4:0]  rd;
      r = $urandom;
      sz = 2'($urandom_range(0, 2));
      ln = (sz == 2'd0) ? r[1:0] : ((sz == 2'd1) ? {r[1], 1'b0} : 2'd0);
      rd = (r[12:8] == 5'd0) ? 5'd1 : r[12:8];
      return mem_op(r[2], sz, r[7:4], ln, $urandom, r[3], rd);
   endfunction

   task automatic issue(input pipe_ctrl_e c, input id_ex_t ins);
      redirect_t er;
      wb_t       ew;
      int        t;
      @(posedge clk);
      t = cyc;
      ctrl <= c;
      id_ex <= ins;
      if (c == ctrl_go) begin
         ref_exec(ins, er, ew);
         if (er.taken) begin
            rd_due_q.push_back(t + 2);
            rd_exp_q.push_back(er);
            rd_tid_q.push_back(cur_test);
         end
         if (ew.valid) begin
            wb_due_q.push_back(t + 3);
            wb_exp_q.push_back(ew);
            wb_tid_q.push_back(cur_test);
         end
      end
   endtask

   function automatic pipe_ctrl_e rand_ctrl();
      int r;
      r = $urandom_range(0, 9);
      if (r < 6)
         return ctrl_go;
      else if (r < 8)
         return ctrl_squash;
      else if (r == 8)
         return ctrl_stall;
      else
         return ctrl_rsvd;
   endfunction

   task automatic finish_test();
      int n;
      n = 0;
      while ((rd_due_q.size() != 0 || wb_due_q.size() != 0) && n < DRAIN_LIMIT) begin
         issue(ctrl_go, '0);
         n++;
      end
      if (rd_due_q.size() != 0 || wb_due_q.size() != 0) begin
         $display("ERROR %s: expected results did not arrive within %0d cycles",
                  tname[cur_test], DRAIN_LIMIT);
         err_cnt[cur_test]++;
      end
      issue(ctrl_go, '0);
      issue(ctrl_go, '0);
      $display("test %s: %0d checks, %0d errors", tname[cur_test],
               chk_cnt[cur_test], err_cnt[cur_test]);
   endtask

   // every cycle either a due result is compared or the outputs must stay quiet.
   always @(negedge clk) begin
      if (rd_due_q.size() != 0 && rd_due_q[0] == cyc) begin
         rd_due_q.delete(0);
         exp_r = rd_exp_q.pop_front();
         tid = rd_tid_q.pop_front();
         chk_cnt[tid]++;
         if (redirect !== exp_r) begin
            $display(
               "MISMATCH %s redirect: expected taken=%0b target=%h actual taken=%0b target=%h",
               tname[tid], exp_r.taken, exp_r.target, redirect.taken, redirect.target);
            err_cnt[tid]++;
         end
      end else begin
         chk_cnt[cur_test]++;
         if (redirect.taken !== 1'b0) begin
            $display("ERROR %s: redirect taken at cycle %0d with no branch or jump captured",
                     tname[cur_test], cyc);
            err_cnt[cur_test]++;
         end
      end
      if (wb_due_q.size() != 0 && wb_due_q[0] == cyc) begin
         wb_due_q.delete(0);
         exp_w = wb_exp_q.pop_front();
         tid = wb_tid_q.pop_front();
         chk_cnt[tid]++;
         if (wb !== exp_w) begin
            $display(
               "MISMATCH %s wb: expected valid=%0b rd=%0d data=%h actual valid=%0b rd=%0d data=%h",
               tname[tid], exp_w.valid, exp_w.rd, exp_w.data, wb.valid, wb.rd, wb.data);
            err_cnt[tid]++;
         end
      end else begin
         chk_cnt[cur_test]++;
         if (wb.valid !== 1'b0) begin
            $display("ERROR %s: writeback to r%0d at cycle %0d with no instruction due",
                     tname[cur_test], wb.rd, cyc);
            err_cnt[cur_test]++;
         end
      end
   end

   initial begin
      int tot_chk;
      int tot_err;
      void'($urandom(32'hd0a2));
      rst = 1'b0;
      ctrl = ctrl_stall;
      id_ex = '0;
      tname[0] = "reset";
      tname[1] = "alu";
      tname[2] = "control_flow";
      tname[3] = "memory";
      tname[4] = "pipeline_ctrl";
      repeat (16) @(posedge clk);
      rst <= 1'b1;

      // nothing is captured while the pipeline is held.
      cur_test = 0;
      repeat (12) issue(ctrl_stall, gen_ctl());
      finish_test();

      cur_test = 1;
      repeat (200) issue(ctrl_go, gen_alu());
      finish_test();

      cur_test = 2;
      repeat (120) issue(ctrl_go, gen_ctl());
      finish_test();

      cur_test = 3;
      for (int w = 0; w < 16; w++) begin
         issue(ctrl_go, mem_op(1'b1, 2'd2, 4'(w), 2'd0, $urandom, 1'b0, 5'd0));
      end
      repeat (160) issue(ctrl_go, gen_mem());
      finish_test();

      cur_test = 4;
      for (int i = 0; i < 200; i++) begin
         case ($urandom_range(0, 2))
            0: issue(rand_ctrl(), gen_alu());
            1: issue(rand_ctrl(), gen_ctl());
            default: issue(rand_ctrl(), gen_mem());
         endcase
      end
      finish_test();

      tot_chk = 0;
      tot_err = 0;
      for (int i = 0; i < 5; i++) begin
         tot_chk += chk_cnt[i];
         tot_err += err_cnt[i];
      end
      $display("total: %0d checks, %0d errors", tot_chk, tot_err);
      if (tot_err == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
src/ex_mem_pkg.sv
src/alu_unit.sv
src/branch_unit.sv
src/ex_mem_reg.sv
src/mem_access.sv
src/ex_mem_top.sv
tests/ex_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   -f sim.f \
   --top-module ex_mem_tb \
   -o ex_mem_sim

./obj_dir/ex_mem_sim | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
